// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_pinmux_reg
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/bist_ser_if.sv ====
module bist_ser_if #(
   parameter int SHIFT_LEN = 32              // Bits per chain access
) (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  logic                          start,
   input  logic                          dir,    // 1 = read
   input  logic [pinmux_pkg::DATA_W-1:0] wdata,
   input  logic                          sdo,
   output logic                          sdi,
   output logic                          shift,
   output logic [pinmux_pkg::DATA_W-1:0] dout,
   output logic                          done
);

   localparam int CNT_W = $clog2(SHIFT_LEN + 1);

   logic [pinmux_pkg::DATA_W-1:0] sreg;     // Shift register
   logic [CNT_W-1:0]              cnt;      // Shifts left
   logic                          rd_mode;  // Latched dir

   // --------------------------------------------------
   // Load on start, shift right while cnt is nonzero
   // --------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         sreg    <= '0;
         cnt     <= '0;
         rd_mode <= 1'b0;
         done    <= 1'b0;
      end
      else
      begin
         done <= shift & (cnt == CNT_W'(1));  // Pulse after last shift
         if (start)
         begin
            cnt     <= CNT_W'(SHIFT_LEN);
            rd_mode <= dir;
            if (!dir)
               sreg <= wdata;                  // Write data to scan out
         end
         else if (shift)
         begin
            cnt  <= cnt - 1'b1;
            sreg <= {sdo, sreg[pinmux_pkg::DATA_W-1:1]};  // Chain out enters MSB
         end
      end
   end

   assign shift = (cnt != '0);

   // A read loops the chain back on itself so its contents survive
   assign sdi  = rd_mode ? sdo : sreg[0];
   assign dout = sreg;  // Held until the next start

endmodule

// ==== hdl/gpio_in_sync.sv ====
module gpio_in_sync (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  logic [pinmux_pkg::DATA_W-1:0] gpio_in_data,
   output logic [pinmux_pkg::DATA_W-1:0] gpio_prev_indata,
   output logic [pinmux_pkg::DATA_W-1:0] gpio_in_cap
);

   logic [pinmux_pkg::DATA_W-1:0] sync_s;   // Metastable stage
   logic [pinmux_pkg::DATA_W-1:0] sync_ss;  // Safe to use

   // Two flop sync, then one capture stage for edge compare
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         sync_s      <= '0;
         sync_ss     <= '0;
         gpio_in_cap <= '0;
      end
      else
      begin
         sync_s      <= gpio_in_data;
         sync_ss     <= sync_s;
         gpio_in_cap <= sync_ss;  // Third edge
      end
   end

   assign gpio_prev_indata = sync_ss;  // Second edge, one ahead of capture

endmodule

// ==== hdl/gpio_int_status.sv ====
module gpio_int_status (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  pinmux_pkg::reg_wen_t          wen,
   input  logic [pinmux_pkg::DATA_W-1:0] wdata,
   input  logic [pinmux_pkg::BE_W-1:0]   be,
   input  logic [pinmux_pkg::DATA_W-1:0] gpio_int_event,
   input  logic [pinmux_pkg::DATA_W-1:0] int_mask,
   output logic [pinmux_pkg::DATA_W-1:0] int_status,
   output logic                          gpio_intr
);

   logic [pinmux_pkg::DATA_W-1:0] status_nxt;

   // --------------------------------------------------
   // Per byte update, then event posting
   // --------------------------------------------------
   always_comb
   begin
      for (int b = 0; b < pinmux_pkg::BE_W; b++)
      begin
         if (wen.int_clr && be[b])
            // Write one to clear
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] & ~wdata[b*8 +: 8];
         else if (wen.int_set && be[b])
            // Write one to set
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8] | wdata[b*8 +: 8];
         else
            status_nxt[b*8 +: 8] = int_status[b*8 +: 8];  // Hold
         // Event beats a clear in the same cycle
         status_nxt[b*8 +: 8] = status_nxt[b*8 +: 8] | gpio_int_event[b*8 +: 8];
      end
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_status <= '0;
      else
         int_status <= status_nxt;  // Updates every edge
   end

   // Combined interrupt to the CPU
   assign gpio_intr = |(int_status & int_mask);

endmodule

// ==== hdl/pinmux_bus_ctrl.sv ====
module pinmux_bus_ctrl (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  pinmux_pkg::reg_req_t          req,
   input  pinmux_pkg::cfg_regs_t         cfg,
   input  logic [pinmux_pkg::DATA_W-1:0] int_status,
   input  logic [pinmux_pkg::DATA_W-1:0] gpio_in_cap,
   input  logic [pinmux_pkg::DATA_W-1:0] ser_dout,
   input  logic                          ser_done,
   output pinmux_pkg::reg_rsp_t          rsp,
   output pinmux_pkg::reg_wen_t          wen,
   output logic                          ser_dir
);

   logic [4:0]                    word_addr;
   logic                          req_q;       // Request seen, not yet acked
   logic                          req_d;
   logic                          req_pedge;
   logic                          wr_first;    // First cycle of a write
   logic                          ser_wr;
   logic                          ser_rd;
   logic                          ser_acc;
   logic                          ack_q;
   logic [pinmux_pkg::DATA_W-1:0] rdata_q;
   logic [pinmux_pkg::DATA_W-1:0] rd_mux;

   assign word_addr = req.addr[6:2];

   // --------------------------------------------------
   // Request edge detect
   // --------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         req_q <= 1'b0;
         req_d <= 1'b0;
      end
      else
      begin
         req_q <= req.cs & ~ack_q;  // Drops in the cycle after ack
         req_d <= req_q;
      end
   end

   assign req_pedge = req_q & ~req_d;          // One cycle after cs rises
   assign wr_first  = req.cs & req.wr & ~req_q;

   // Scan chain accesses wait for the shifter
   assign ser_wr  = req.cs & req.wr & (word_addr == pinmux_pkg::ADR_SER_WR);
   assign ser_rd  = req.cs & ~req.wr & (word_addr == pinmux_pkg::ADR_SER_RD);
   assign ser_acc = ser_wr | ser_rd;
   assign ser_dir = ser_rd;                    // High for a chain read

   // Write strobes
   always_comb
   begin
      wen           = '0;
      wen.glb       = wr_first & (word_addr == pinmux_pkg::ADR_GLB_CTRL);
      wen.gpio_out  = wr_first & (word_addr == pinmux_pkg::ADR_GPIO_OUT);
      wen.gpio_dir  = wr_first & (word_addr == pinmux_pkg::ADR_GPIO_DIR);
      wen.int_clr   = wr_first & (word_addr == pinmux_pkg::ADR_INT_STAT);
      wen.int_set   = wr_first & (word_addr == pinmux_pkg::ADR_INT_SET);
      wen.int_mask  = wr_first & (word_addr == pinmux_pkg::ADR_INT_MASK);
      wen.pos_sel   = wr_first & (word_addr == pinmux_pkg::ADR_POS_SEL);
      wen.neg_sel   = wr_first & (word_addr == pinmux_pkg::ADR_NEG_SEL);
      wen.bist_ctrl = wr_first & (word_addr == pinmux_pkg::ADR_BIST_CTRL);
      wen.ser_start = req_pedge & ser_acc;
   end

   // --------------------------------------------------
   // Read multiplexer, holes read zero
   // --------------------------------------------------
   always_comb
   begin
      case (word_addr)
         pinmux_pkg::ADR_CHIP_ID   : rd_mux = pinmux_pkg::CHIP_ID;
         pinmux_pkg::ADR_GLB_CTRL  : rd_mux = cfg.glb_ctrl;
         pinmux_pkg::ADR_GPIO_IN   : rd_mux = gpio_in_cap;
         pinmux_pkg::ADR_GPIO_OUT  : rd_mux = cfg.gpio_out;
         pinmux_pkg::ADR_GPIO_DIR  : rd_mux = cfg.gpio_dir;
         pinmux_pkg::ADR_INT_STAT,
         pinmux_pkg::ADR_INT_SET   : rd_mux = int_status;  // Set reg mirrors status
         pinmux_pkg::ADR_INT_MASK  : rd_mux = cfg.int_mask;
         pinmux_pkg::ADR_POS_SEL   : rd_mux = cfg.pos_sel;
         pinmux_pkg::ADR_NEG_SEL   : rd_mux = cfg.neg_sel;
         pinmux_pkg::ADR_BIST_CTRL : rd_mux = {29'd0, cfg.bist_ctrl};
         pinmux_pkg::ADR_SER_WR,
         pinmux_pkg::ADR_SER_RD    : rd_mux = ser_dout;    // Last shifted data
         default                   : rd_mux = '0;
      endcase
   end

   // Ack at once for plain regs, on ser_done for the chain
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         ack_q <= 1'b0;
      else if (ser_acc)
         ack_q <= ser_done;
      else
         ack_q <= req.cs & ~ack_q;
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         rdata_q <= '0;
      else
         rdata_q <= rd_mux;  // Captured with ack
   end

   assign rsp.rdata = rdata_q;
   assign rsp.ack   = ack_q;

endmodule

// ==== hdl/pinmux_cfg_bank.sv ====
module pinmux_cfg_bank (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  pinmux_pkg::reg_wen_t          wen,
   input  logic [pinmux_pkg::DATA_W-1:0] wdata,
   input  logic [pinmux_pkg::BE_W-1:0]   be,
   output pinmux_pkg::cfg_regs_t         cfg
);

   // Replace only the enabled bytes
   function automatic logic [pinmux_pkg::DATA_W-1:0] be_merge(
      input logic [pinmux_pkg::DATA_W-1:0] old_val,
      input logic [pinmux_pkg::DATA_W-1:0] new_val,
      input logic [pinmux_pkg::BE_W-1:0]   byte_en
   );
      logic [pinmux_pkg::DATA_W-1:0] res;
      res = old_val;
      for (int b = 0; b < pinmux_pkg::BE_W; b++)
      begin
         if (byte_en[b])
            res[b*8 +: 8] = new_val[b*8 +: 8];
      end
      return res;
   endfunction

   // --------------------------------------------------
   // Control registers
   // --------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         cfg.glb_ctrl  <= pinmux_pkg::GLB_CTRL_RST;  // Peripherals and CPU in reset
         cfg.gpio_out  <= '0;
         cfg.gpio_dir  <= '0;                        // All pins input
         cfg.int_mask  <= '0;
         cfg.pos_sel   <= '0;
         cfg.neg_sel   <= '0;
         cfg.bist_ctrl <= '0;
      end
      else
      begin
         if (wen.glb)      cfg.glb_ctrl <= be_merge(cfg.glb_ctrl, wdata, be);
         if (wen.gpio_out) cfg.gpio_out <= be_merge(cfg.gpio_out, wdata, be);
         if (wen.gpio_dir) cfg.gpio_dir <= be_merge(cfg.gpio_dir, wdata, be);
         if (wen.int_mask) cfg.int_mask <= be_merge(cfg.int_mask, wdata, be);
         if (wen.pos_sel)  cfg.pos_sel  <= be_merge(cfg.pos_sel, wdata, be);
         if (wen.neg_sel)  cfg.neg_sel  <= be_merge(cfg.neg_sel, wdata, be);
         // BIST control lives in byte 0 only
         if (wen.bist_ctrl && be[0])
            cfg.bist_ctrl <= wdata[2:0];
      end
   end

endmodule

// ==== hdl/pinmux_pkg.sv ====
package pinmux_pkg;

   // Bus widths
   localparam int DATA_W = 32;
   localparam int BE_W   = 4;                     // One enable per byte
   localparam int ADDR_W = 8;                     // Byte address

   // --------------------------------------------------
   // Word addresses, byte address bits 6:2
   // --------------------------------------------------
   localparam logic [4:0] ADR_CHIP_ID   = 5'd0;
   localparam logic [4:0] ADR_GLB_CTRL  = 5'd2;
   localparam logic [4:0] ADR_GPIO_IN   = 5'd4;   // Read only
   localparam logic [4:0] ADR_GPIO_OUT  = 5'd5;
   localparam logic [4:0] ADR_GPIO_DIR  = 5'd6;
   localparam logic [4:0] ADR_INT_STAT  = 5'd9;   // W1C
   localparam logic [4:0] ADR_INT_SET   = 5'd10;  // W1S, reads status
   localparam logic [4:0] ADR_INT_MASK  = 5'd11;
   localparam logic [4:0] ADR_POS_SEL   = 5'd12;
   localparam logic [4:0] ADR_NEG_SEL   = 5'd13;
   localparam logic [4:0] ADR_BIST_CTRL = 5'd28;
   localparam logic [4:0] ADR_SER_WR    = 5'd30;  // Scan chain write
   localparam logic [4:0] ADR_SER_RD    = 5'd31;  // Scan chain read

   // Manufacturer, core count, chip number, revision
   localparam logic [DATA_W-1:0] CHIP_ID      = {16'h4d43, 4'h1, 4'h2, 8'h01};
   localparam logic [DATA_W-1:0] GLB_CTRL_RST = '0;  // Every block held in reset

   // --------------------------------------------------
   // Bus and internal bundles
   // --------------------------------------------------
   typedef struct packed {
      logic              cs;                      // Level select, held until ack
      logic              wr;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;
   } reg_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ack;                     // Single cycle pulse
   } reg_rsp_t;

   typedef struct packed {
      logic glb;
      logic gpio_out;
      logic gpio_dir;
      logic int_clr;
      logic int_set;
      logic int_mask;
      logic pos_sel;
      logic neg_sel;
      logic bist_ctrl;
      logic ser_start;                            // Scan access start, read or write
   } reg_wen_t;

   typedef struct packed {
      logic [DATA_W-1:0] glb_ctrl;
      logic [DATA_W-1:0] gpio_out;
      logic [DATA_W-1:0] gpio_dir;
      logic [DATA_W-1:0] int_mask;
      logic [DATA_W-1:0] pos_sel;
      logic [DATA_W-1:0] neg_sel;
      logic [2:0]        bist_ctrl;               // load, run, en
   } cfg_regs_t;

   typedef struct packed {
      logic [1:0] cpu_core_rst_n;
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic       uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
   } rst_ctrl_t;

   typedef struct packed {
      logic [DATA_W-1:0] out_data;
      logic [DATA_W-1:0] dir_sel;
      logic [DATA_W-1:0] posedge_sel;
      logic [DATA_W-1:0] negedge_sel;
      logic [DATA_W-1:0] data_in;
   } gpio_cfg_t;

   typedef struct packed {
      logic en;
      logic run;
      logic load;
      logic sdi;
      logic shift;
   } bist_ctrl_t;

endpackage

// ==== hdl/pinmux_reg.sv ====
module pinmux_reg #(
   parameter int SHIFT_LEN = 32
) (
   input  logic                          mclk,
   input  logic                          h_reset_n,
   input  pinmux_pkg::reg_req_t          req,
   output pinmux_pkg::reg_rsp_t          rsp,
   input  logic [pinmux_pkg::DATA_W-1:0] gpio_in_data,
   input  logic [pinmux_pkg::DATA_W-1:0] gpio_int_event,
   input  logic                          bist_sdo,
   output pinmux_pkg::rst_ctrl_t         rst_ctrl,
   output pinmux_pkg::gpio_cfg_t         gpio_cfg,
   output logic [pinmux_pkg::DATA_W-1:0] gpio_prev_indata,
   output pinmux_pkg::bist_ctrl_t        bist_ctrl,
   output logic                          gpio_intr
);

   pinmux_pkg::reg_wen_t          wen;
   pinmux_pkg::cfg_regs_t         cfg;
   logic [pinmux_pkg::DATA_W-1:0] int_status;
   logic [pinmux_pkg::DATA_W-1:0] gpio_in_cap;
   logic [pinmux_pkg::DATA_W-1:0] ser_dout;
   logic                          ser_done;
   logic                          ser_dir;

   // --------------------------------------------------
   // Bus decode and read back
   // --------------------------------------------------
   pinmux_bus_ctrl i_bus_ctrl (
      .mclk        (mclk),
      .h_reset_n   (h_reset_n),
      .req         (req),
      .cfg         (cfg),
      .int_status  (int_status),
      .gpio_in_cap (gpio_in_cap),
      .ser_dout    (ser_dout),
      .ser_done    (ser_done),
      .rsp         (rsp),
      .wen         (wen),
      .ser_dir     (ser_dir)
   );

   pinmux_cfg_bank i_cfg_bank (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .wen       (wen),
      .wdata     (req.wdata),
      .be        (req.be),
      .cfg       (cfg)
   );

   gpio_in_sync i_gpio_in_sync (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .gpio_in_data     (gpio_in_data),
      .gpio_prev_indata (gpio_prev_indata),
      .gpio_in_cap      (gpio_in_cap)
   );

   gpio_int_status i_gpio_int_status (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .wen            (wen),
      .wdata          (req.wdata),
      .be             (req.be),
      .gpio_int_event (gpio_int_event),
      .int_mask       (cfg.int_mask),
      .int_status     (int_status),
      .gpio_intr      (gpio_intr)
   );

   bist_ser_if #(
      .SHIFT_LEN (SHIFT_LEN)
   ) i_bist_ser_if (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .start     (wen.ser_start),
      .dir       (ser_dir),
      .wdata     (req.wdata),
      .sdo       (bist_sdo),
      .sdi       (bist_ctrl.sdi),
      .shift     (bist_ctrl.shift),
      .dout      (ser_dout),
      .done      (ser_done)
   );

   // --------------------------------------------------
   // Global control bit map
   // --------------------------------------------------
   assign rst_ctrl.cpu_intf_rst_n = cfg.glb_ctrl[0];
   assign rst_ctrl.qspim_rst_n    = cfg.glb_ctrl[1];
   assign rst_ctrl.sspim_rst_n    = cfg.glb_ctrl[2];
   assign rst_ctrl.uart_rst_n     = cfg.glb_ctrl[3];
   assign rst_ctrl.i2cm_rst_n     = cfg.glb_ctrl[4];
   assign rst_ctrl.usb_rst_n      = cfg.glb_ctrl[5];
   assign rst_ctrl.cpu_core_rst_n = cfg.glb_ctrl[9:8];  // One per core

   // GPIO config to the pad block
   assign gpio_cfg.out_data    = cfg.gpio_out;
   assign gpio_cfg.dir_sel     = cfg.gpio_dir;
   assign gpio_cfg.posedge_sel = cfg.pos_sel;
   assign gpio_cfg.negedge_sel = cfg.neg_sel;
   assign gpio_cfg.data_in     = gpio_in_cap;  // Same as the read value

   assign bist_ctrl.en   = cfg.bist_ctrl[0];
   assign bist_ctrl.run  = cfg.bist_ctrl[1];
   assign bist_ctrl.load = cfg.bist_ctrl[2];

endmodule

// ==== test/pinmux_reg_checker.sv ====
module pinmux_reg_checker (
   input logic                   mclk,
   input logic                   h_reset_n,
   input pinmux_pkg::reg_req_t   req,
   input pinmux_pkg::reg_rsp_t   rsp,
   input pinmux_pkg::bist_ctrl_t bist_ctrl
);

   // --------------------------------------------------
   // Bus protocol
   // --------------------------------------------------
   ack_in_reset: assert property (@(posedge mclk) !h_reset_n |-> !rsp.ack)
      else $error("ack high while reset is asserted");

   // Ack is a single cycle pulse
   ack_single: assert property (@(posedge mclk) disable iff (!h_reset_n)
      rsp.ack |=> !rsp.ack)
      else $error("ack high for two cycles in a row");

   shift_in_access: assert property (@(posedge mclk) disable iff (!h_reset_n)
      bist_ctrl.shift |-> req.cs)                  // Scan only inside an access
      else $error("bist_shift high without a bus request");

endmodule

bind pinmux_reg pinmux_reg_checker i_checker (
   .mclk      (mclk),
   .h_reset_n (h_reset_n),
   .req       (req),
   .rsp       (rsp),
   .bist_ctrl (bist_ctrl)
);

// ==== test/tb_pinmux_reg.sv ====
module tb_pinmux_reg;

   localparam int SHIFT_LEN = 32;
   // About 50 plain accesses of 2 cycles plus 3 scan accesses of 37 cycles
   localparam int MAX_CYCLES = 2000;
   localparam logic [31:0] CHAIN_INIT = 32'hc3a5_5a3c;  // Chain contents out of reset

   logic                          mclk;
   logic                          h_reset_n;
   pinmux_pkg::reg_req_t          req;
   pinmux_pkg::reg_rsp_t          rsp;
   logic [pinmux_pkg::DATA_W-1:0] gpio_in_data;
   logic [pinmux_pkg::DATA_W-1:0] gpio_int_event;
   logic                          bist_sdo = 1'b0;
   pinmux_pkg::rst_ctrl_t         rst_ctrl;
   pinmux_pkg::gpio_cfg_t         gpio_cfg;
   logic [pinmux_pkg::DATA_W-1:0] gpio_prev_indata;
   pinmux_pkg::bist_ctrl_t        bist_ctrl;
   logic                          gpio_intr;

   logic [31:0] chain;              // BIST chain model
   int          shift_cnt = 0;      // Cycles seen with bist_shift high
   int          cycles = 0;

   pinmux_reg #(
      .SHIFT_LEN (SHIFT_LEN)
   ) i_dut (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .req              (req),
      .rsp              (rsp),
      .gpio_in_data     (gpio_in_data),
      .gpio_int_event   (gpio_int_event),
      .bist_sdo         (bist_sdo),
      .rst_ctrl         (rst_ctrl),
      .gpio_cfg         (gpio_cfg),
      .gpio_prev_indata (gpio_prev_indata),
      .bist_ctrl        (bist_ctrl),
      .gpio_intr        (gpio_intr)
   );

   initial
   begin
      mclk = 1'b0;
      forever #2 mclk = ~mclk;
   end

   // --------------------------------------------------
   // Scan chain model and cycle limit
   // --------------------------------------------------
   always @(posedge mclk)
   begin
      if (!h_reset_n)
         chain <= CHAIN_INIT;
      else if (bist_ctrl.shift)
         chain <= {bist_ctrl.sdi, chain[31:1]};  // sdi enters the top bit
   end

   always @(negedge mclk)
   begin
      bist_sdo <= chain[0];                      // Chain out from low bit
      if (bist_ctrl.shift)
         shift_cnt <= shift_cnt + 1;
   end

   always @(posedge mclk)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("Some tests failed");
      $fatal(1, "run stopped at first error");
   endtask

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_word(input string name, input logic [pinmux_pkg::DATA_W-1:0] exp,
                             input logic [pinmux_pkg::DATA_W-1:0] act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_rst(input string name, input pinmux_pkg::rst_ctrl_t exp,
                            input pinmux_pkg::rst_ctrl_t act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
         abort_run();
      end
   endtask

   // Old bytes kept where be is low
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0] be);
      logic [31:0] mask;
      mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
      return (old_val & ~mask) | (new_val & mask);
   endfunction

   function automatic pinmux_pkg::rst_ctrl_t rst_from_glb(input logic [31:0] g);
      pinmux_pkg::rst_ctrl_t r;
      r.cpu_core_rst_n = g[9:8];
      r.cpu_intf_rst_n = g[0];
      r.qspim_rst_n    = g[1];
      r.sspim_rst_n    = g[2];
      r.uart_rst_n     = g[3];
      r.i2cm_rst_n     = g[4];
      r.usb_rst_n      = g[5];
      return r;
   endfunction

   // --------------------------------------------------
   // Bus access, called on a falling edge
   // --------------------------------------------------
   task automatic bus_access(input logic wr, input logic [4:0] word, input logic [31:0] wdata,
                             input logic [3:0] be, output logic [31:0] rdata);
      req.cs    = 1'b1;
      req.wr    = wr;
      req.addr  = {1'b0, word, 2'b00};
      req.wdata = wdata;
      req.be    = be;
      @(negedge mclk);
      while (!rsp.ack)
         @(negedge mclk);                        // Wait for the ack pulse
      rdata = rsp.rdata;
      req   = '0;
      @(negedge mclk);                           // No new request in the ack cycle
   endtask

   task automatic write_reg(input logic [4:0] word, input logic [31:0] data,
                            input logic [3:0] be);
      logic [31:0] unused;
      bus_access(1'b1, word, data, be, unused);
   endtask

   task automatic read_reg(input logic [4:0] word, output logic [31:0] data);
      bus_access(1'b0, word, 32'd0, 4'd0, data);
   endtask

   // --------------------------------------------------
   // Directed tests
   // --------------------------------------------------
   task automatic test_reset();
      logic [31:0] rd;
      read_reg(pinmux_pkg::ADR_CHIP_ID, rd);
      check_word("test_reset chip id", pinmux_pkg::CHIP_ID, rd);
      check_rst("test_reset rst_ctrl", '0, rst_ctrl);
      write_reg(5'd20, 32'hffff_ffff, 4'hf);     // Hole, write ignored
      read_reg(5'd20, rd);
      check_word("test_reset unmapped", 32'd0, rd);
   endtask

   task automatic test_cfg_regs();
      logic [4:0]  adr [6];
      logic [31:0] shadow [6];
      logic [31:0] data;
      logic [3:0]  be;
      logic [31:0] rd;
      adr = '{pinmux_pkg::ADR_GLB_CTRL, pinmux_pkg::ADR_GPIO_OUT, pinmux_pkg::ADR_GPIO_DIR,
              pinmux_pkg::ADR_INT_MASK, pinmux_pkg::ADR_POS_SEL, pinmux_pkg::ADR_NEG_SEL};
      shadow = '{default: '0};
      for (int round = 0; round < 3; round++)
      begin
         for (int i = 0; i < 6; i++)
         begin
            data = $urandom;
            be   = 4'($urandom_range(15, 0));
            write_reg(adr[i], data, be);
            shadow[i] = merge_bytes(shadow[i], data, be);
            read_reg(adr[i], rd);
            check_word("test_cfg_regs readback", shadow[i], rd);
         end
         check_rst("test_cfg_regs rst_ctrl", rst_from_glb(shadow[0]), rst_ctrl);
         check_word("test_cfg_regs out_data", shadow[1], gpio_cfg.out_data);
         check_word("test_cfg_regs dir_sel", shadow[2], gpio_cfg.dir_sel);
         check_word("test_cfg_regs posedge_sel", shadow[4], gpio_cfg.posedge_sel);
         check_word("test_cfg_regs negedge_sel", shadow[5], gpio_cfg.negedge_sel);
      end
      // BIST control in byte 0, each bit seen at both levels
      data = $urandom;
      for (int n = 0; n < 2; n++)
      begin
         write_reg(pinmux_pkg::ADR_BIST_CTRL, data, 4'h1);
         read_reg(pinmux_pkg::ADR_BIST_CTRL, rd);
         check_word("test_cfg_regs bist_ctrl", {29'd0, data[2:0]}, rd);
         check_bit("test_cfg_regs bist_en", data[0], bist_ctrl.en);
         check_bit("test_cfg_regs bist_run", data[1], bist_ctrl.run);
         check_bit("test_cfg_regs bist_load", data[2], bist_ctrl.load);
         data = ~data;
      end
   endtask

   task automatic test_gpio_in();
      logic [31:0] val;
      logic [31:0] rd;
      val = $urandom;
      gpio_in_data = val;
      repeat (4) @(negedge mclk);                // Three edges to the capture stage
      check_word("test_gpio_in data_in", val, gpio_cfg.data_in);
      check_word("test_gpio_in prev_indata", val, gpio_prev_indata);
      read_reg(pinmux_pkg::ADR_GPIO_IN, rd);
      check_word("test_gpio_in readback", val, rd);
   endtask

   task automatic test_interrupts();
      int          k;
      int          e;
      logic [31:0] stat;
      logic [31:0] set_val;
      logic [31:0] wdata;
      logic [3:0]  be;
      logic [31:0] rd;
      k = $urandom_range(31, 0);
      write_reg(pinmux_pkg::ADR_INT_MASK, 32'd0, 4'hf);
      gpio_int_event = 32'd1 << k;               // One cycle event pulse
      @(negedge mclk);
      gpio_int_event = '0;
      stat = 32'd1 << k;
      read_reg(pinmux_pkg::ADR_INT_STAT, rd);
      check_word("test_interrupts event", stat, rd);
      check_bit("test_interrupts masked", 1'b0, gpio_intr);
      write_reg(pinmux_pkg::ADR_INT_MASK, 32'd1 << k, 4'hf);
      check_bit("test_interrupts unmasked", 1'b1, gpio_intr);
      // W1S
      set_val = $urandom;
      write_reg(pinmux_pkg::ADR_INT_SET, set_val, 4'hf);
      stat = stat | set_val;
      read_reg(pinmux_pkg::ADR_INT_STAT, rd);
      check_word("test_interrupts set", stat, rd);
      // W1C with an event landing in the same cycle
      e     = $urandom_range(31, 0);
      wdata = $urandom | (32'd1 << e);           // Clear aims at the event bit
      be    = 4'($urandom_range(15, 0)) | (4'd1 << (e / 8));
      gpio_int_event = 32'd1 << e;
      fork
         write_reg(pinmux_pkg::ADR_INT_STAT, wdata, be);
         begin
            @(negedge mclk);
            gpio_int_event = '0;                 // Only the strobe edge sees it
         end
      join
      stat = (stat & ~merge_bytes(32'd0, wdata, be)) | (32'd1 << e);
      read_reg(pinmux_pkg::ADR_INT_STAT, rd);
      check_word("test_interrupts clear", stat, rd);
      check_bit("test_interrupts intr", |(stat & (32'd1 << k)), gpio_intr);
   endtask

   task automatic test_bist_chain();
      logic [31:0] w;
      logic [31:0] v;
      logic [31:0] rd;
      int          base;
      w    = $urandom;
      v    = $urandom;
      base = shift_cnt;
      bus_access(1'b1, pinmux_pkg::ADR_SER_WR, w, 4'hf, rd);
      check_word("test_bist_chain first out", CHAIN_INIT, rd);
      check_word("test_bist_chain shifts 1", 32'(SHIFT_LEN), 32'(shift_cnt - base));
      base = shift_cnt;
      bus_access(1'b1, pinmux_pkg::ADR_SER_WR, v, 4'hf, rd);
      check_word("test_bist_chain second out", w, rd);
      check_word("test_bist_chain shifts 2", 32'(SHIFT_LEN), 32'(shift_cnt - base));
      base = shift_cnt;
      read_reg(pinmux_pkg::ADR_SER_RD, rd);     // Chain loops back on itself
      check_word("test_bist_chain read", v, rd);
      check_word("test_bist_chain shifts 3", 32'(SHIFT_LEN), 32'(shift_cnt - base));
      check_word("test_bist_chain kept", v, chain);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial
   begin
      void'($urandom(32'h52f5_d8d6));
      req            = '0;
      gpio_in_data   = '0;
      gpio_int_event = '0;
      h_reset_n      = 1'b0;
      repeat (4) @(negedge mclk);
      h_reset_n = 1'b1;
      @(negedge mclk);
      test_reset();
      test_cfg_regs();
      test_gpio_in();
      test_interrupts();
      test_bist_chain();
      $display("All tests passed");
      $finish;
   end

endmodule

// ==== vlog.f ====
hdl/pinmux_pkg.sv
hdl/pinmux_bus_ctrl.sv
hdl/pinmux_cfg_bank.sv
hdl/gpio_in_sync.sv
hdl/gpio_int_status.sv
hdl/bist_ser_if.sv
hdl/pinmux_reg.sv
test/pinmux_reg_checker.sv
test/tb_pinmux_reg.sv
